// File: fp_subsystem.f
rtl/fp_pkg.sv
rtl/fp_decoder.sv
rtl/fp_regfile.sv
rtl/fp_alu.sv
rtl/fp_subsystem.sv
tb/fp_checker.sv
tb/tb_fp_subsystem.sv

// File: Bender.yml
package:
  name: fp_subsystem

sources:
  # Package first, then leaf modules, then the top level
  - rtl/fp_pkg.sv
  - rtl/fp_decoder.sv
  - rtl/fp_regfile.sv
  - rtl/fp_alu.sv
  - rtl/fp_subsystem.sv

  - target: simulation
    files:
      - tb/fp_checker.sv
      - tb/tb_fp_subsystem.sv

// File: tb/tb_fp_subsystem.sv
// Top-level testbench for the FP register subsystem.
// Runs reset, load, sign-injection, min/max, move and illegal phases with
// random instructions; fp_checker does all comparing.

`timescale 1ns/1ps

module tb_fp_subsystem;

  localparam int unsigned ClkPeriod = 8;
  localparam int unsigned NumRand   = 200;
  // Six special loads, then FMIN and FMAX over every ordered pair
  localparam int unsigned NumCorner = 6 + 6 * 6 * 2;
  // Reset, six 32-cycle sweeps or fills, random phases, corners, tail
  localparam int unsigned NumCycles = 3 + 32 * 6 + NumRand * 2 + NumRand / 4 + NumCorner + 8;
  localparam int unsigned Timeout   = (NumCycles + 100) * ClkPeriod;

  logic        clk_i;
  logic        rst_ni;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic [31:0] load_data_i;
  logic [31:0] int_data_i;
  logic [4:0]  dbg_raddr_i;
  logic        store_valid_o;
  logic [31:0] store_data_o;
  logic        int_valid_o;
  logic [31:0] int_data_o;
  logic        illegal_o;
  logic [31:0] dbg_rdata_o;
  int unsigned errors;
  int unsigned checks;

  fp_subsystem fp_subsystem_i (
    .clk_i, .rst_ni, .instr_valid_i, .instr_i, .load_data_i, .int_data_i, .dbg_raddr_i,
    .store_valid_o, .store_data_o, .int_valid_o, .int_data_o, .illegal_o, .dbg_rdata_o
  );

  fp_checker u_checker (
    .clk_i, .rst_ni, .instr_valid_i, .instr_i, .load_data_i, .int_data_i, .dbg_raddr_i,
    .store_valid_i (store_valid_o),
    .store_data_i  (store_data_o),
    .int_valid_i   (int_valid_o),
    .int_data_o_i  (int_data_o),
    .illegal_i     (illegal_o),
    .dbg_rdata_i   (dbg_rdata_o),
    .errors_o      (errors),
    .checks_o      (checks)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // Watchdog
  initial begin
    #(Timeout);
    $display("Timeout after %0d ns, stimulus did not complete", Timeout);
    $display("TEST FAILED");
    $finish;
  end

  // OP-FP encoding, funct7 holds funct5 and fmt
  function automatic logic [31:0] op_fp_word(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rs2, input logic [4:0] rs1,
                                             input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, fp_pkg::OpcodeOpFp};
  endfunction

  function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [4:0] rs1);
    return {12'($urandom), rs1, 3'b010, rd, fp_pkg::OpcodeLoadFp};
  endfunction

  function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1);
    return {7'($urandom), rs2, rs1, 3'b010, 5'($urandom), fp_pkg::OpcodeStoreFp};
  endfunction

  // Half random, half zeros, infinities, NaNs, denormals and ones
  function automatic logic [31:0] pick_value();
    logic [31:0] r;
    r = $urandom;
    if (r[0]) return $urandom;
    case (r[4:1])
      4'd0:    return 32'h0000_0000;
      4'd1:    return 32'h8000_0000;
      4'd2:    return 32'h7f80_0000;
      4'd3:    return 32'hff80_0000;
      4'd4:    return 32'h7fc0_0000;
      4'd5:    return 32'h7fa0_0001;
      4'd6:    return 32'hffc0_1234;
      4'd7:    return 32'h0000_0001;
      4'd8:    return 32'h807f_ffff;
      4'd9:    return 32'h3f80_0000;
      4'd10:   return 32'hbf80_0000;
      default: return $urandom;
    endcase
  endfunction

  // Unsupported encodings of several kinds
  function automatic logic [31:0] illegal_word();
    logic [31:0] r;
    logic [31:0] w;
    r = $urandom;
    case (r[2:0])
      3'd0:    w = op_fp_word(7'h11, r[5:3], r[10:6], r[15:11], r[20:16]);
      3'd1:    w = op_fp_word(7'h00, r[5:3], r[10:6], r[15:11], r[20:16]);
      3'd2:    w = {r[31:7], 7'h33};
      3'd3:    w = {r[31:15], 3'b011, r[11:7], fp_pkg::OpcodeLoadFp};
      // FMV.X.W or FMV.W.X with a nonzero rs2 field
      3'd4:    w = op_fp_word(r[3] ? 7'h70 : 7'h78, 3'b000, r[8:4] | 5'd1, r[13:9], r[18:14]);
      // Sign injection or min/max with funct3 out of range
      default: w = op_fp_word(r[3] ? 7'h14 : 7'h10, {1'b1, r[5:4]}, r[10:6], r[15:11],
                              r[20:16]);
    endcase
    return w;
  endfunction

  task automatic issue(input logic [31:0] word, input logic [31:0] ld, input logic [31:0] id);
    @(posedge clk_i);
    instr_valid_i <= 1'b1;
    instr_i       <= word;
    load_data_i   <= ld;
    int_data_i    <= id;
    dbg_raddr_i   <= 5'($urandom);
  endtask

  // Idle cycles reading every register, garbage on instr_i
  task automatic sweep_debug();
    for (int i = 0; i < 32; i++) begin
      @(posedge clk_i);
      instr_valid_i <= 1'b0;
      instr_i       <= $urandom;
      dbg_raddr_i   <= 5'(i);
    end
  endtask

  // FLW or FMV.W.X, other data port gets noise
  task automatic load_reg(input logic [4:0] rd);
    logic [31:0] value;
    value = pick_value();
    if ($urandom_range(1, 0) == 0) begin
      issue(load_word(rd, 5'($urandom)), value, $urandom);
    end else begin
      issue(op_fp_word(7'h78, 3'b000, 5'd0, 5'($urandom), rd), $urandom, value);
    end
  endtask

  // Signed zeros and NaN pairs in f24 to f29, results into f30 and f31
  task automatic minmax_corners();
    logic [31:0] specials [6];
    specials = '{32'h0000_0000, 32'h8000_0000, 32'h7fc0_0000,
                 32'h7fa0_0001, 32'hffc0_1234, 32'h3f80_0000};
    for (int i = 0; i < 6; i++) begin
      issue(load_word(5'(24 + i), 5'($urandom)), specials[i], $urandom);
    end
    for (int a = 0; a < 6; a++) begin
      for (int b = 0; b < 6; b++) begin
        for (int f = 0; f < 2; f++) begin
          issue(op_fp_word(7'h14, 3'(f), 5'(24 + b), 5'(24 + a), 5'(30 + f)),
                $urandom, $urandom);
        end
      end
    end
  endtask

  initial begin
    void'($urandom(32'h4505));
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = 32'd0;
    load_data_i   = 32'd0;
    int_data_i    = 32'd0;
    dbg_raddr_i   = 5'd0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Reset state
    sweep_debug();
    // Fill all registers, then store each one
    for (int r = 0; r < 32; r++) load_reg(5'(r));
    for (int r = 0; r < 32; r++) issue(store_word(5'(r), 5'($urandom)), $urandom, $urandom);
    // Sign injection on a small register window for dependencies
    for (int n = 0; n < NumRand; n++) begin
      issue(op_fp_word(7'h10, 3'($urandom_range(2, 0)), 5'($urandom_range(7, 0)),
                       5'($urandom_range(7, 0)), 5'($urandom_range(7, 0))), $urandom, $urandom);
    end
    // Min and max over a fresh special-heavy fill
    for (int r = 0; r < 32; r++) load_reg(5'(r));
    for (int n = 0; n < NumRand; n++) begin
      issue(op_fp_word(7'h14, 3'($urandom_range(1, 0)), 5'($urandom), 5'($urandom),
                       5'($urandom_range(7, 0))), $urandom, $urandom);
    end
    minmax_corners();
    // FMV.X.W of every register
    for (int r = 0; r < 32; r++) begin
      issue(op_fp_word(7'h70, 3'b000, 5'd0, 5'(r), 5'($urandom)), $urandom, $urandom);
    end
    // Illegal encodings, then confirm registers untouched
    for (int n = 0; n < NumRand / 4; n++) issue(illegal_word(), $urandom, $urandom);
    sweep_debug();
    repeat (4) @(posedge clk_i);
    $display("Checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: tb/fp_checker.sv
// Scoreboard for the FP register subsystem testbench.
// Decodes each strobed instruction on its own, keeps a 32-entry register
// model and compares pulses, data and debug reads on the falling edge.

`timescale 1ns/1ps

module fp_checker (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,
  input  logic [31:0] load_data_i,
  input  logic [31:0] int_data_i,
  input  logic [4:0]  dbg_raddr_i,
  input  logic        store_valid_i,
  input  logic [31:0] store_data_i,
  input  logic        int_valid_i,
  input  logic [31:0] int_data_o_i,
  input  logic        illegal_i,
  input  logic [31:0] dbg_rdata_i,
  output int unsigned errors_o,
  output int unsigned checks_o
);

  // Expected registered outputs after an edge
  typedef struct packed {
    logic        store;
    logic        mv_x;
    logic        illegal;
    logic [31:0] store_data;
    logic [31:0] int_data;
  } expect_t;

  logic [31:0]    ref_regs [32];
  expect_t        exp_q;
  fp_pkg::fp_op_e op;
  logic [31:0]    res;
  int unsigned    err_cnt = 0;
  int unsigned    chk_cnt = 0;

  assign errors_o = err_cnt;
  assign checks_o = chk_cnt;

  // Decode from the RISC-V encoding tables
  function automatic fp_pkg::fp_op_e classify(input logic [31:0] w);
    logic [2:0]     f3;
    logic [6:0]     f7;
    logic [4:0]     r2;
    fp_pkg::fp_op_e kind;
    f3   = w[14:12];
    f7   = w[31:25];
    r2   = w[24:20];
    kind = fp_pkg::FpNone;
    if (w[6:0] == fp_pkg::OpcodeLoadFp && f3 == 3'b010) begin
      kind = fp_pkg::FpLoad;
    end else if (w[6:0] == fp_pkg::OpcodeStoreFp && f3 == 3'b010) begin
      kind = fp_pkg::FpStore;
    end else if (w[6:0] == fp_pkg::OpcodeOpFp) begin
      case (f7)
        7'h10: begin
          if (f3 == 3'd0) kind = fp_pkg::FpSgnj;
          if (f3 == 3'd1) kind = fp_pkg::FpSgnjn;
          if (f3 == 3'd2) kind = fp_pkg::FpSgnjx;
        end
        7'h14: begin
          if (f3 == 3'd0) kind = fp_pkg::FpMin;
          if (f3 == 3'd1) kind = fp_pkg::FpMax;
        end
        7'h70: if (r2 == 5'd0 && f3 == 3'd0) kind = fp_pkg::FpMvXW;
        7'h78: if (r2 == 5'd0 && f3 == 3'd0) kind = fp_pkg::FpMvWX;
        default: kind = fp_pkg::FpNone;
      endcase
    end
    return kind;
  endfunction

  function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  // Monotonic unsigned key for sign-magnitude values; -0 sits below +0
  function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : {1'b1, x[30:0]};
  endfunction

  // Expected result of one operation
  function automatic logic [31:0] ref_result(input fp_pkg::fp_op_e kind,
                                             input logic [31:0] a, input logic [31:0] b,
                                             input logic [31:0] ld, input logic [31:0] id);
    logic a_lo;
    a_lo = order_key(a) < order_key(b);
    case (kind)
      fp_pkg::FpSgnj:  return {b[31], a[30:0]};
      fp_pkg::FpSgnjn: return {~b[31], a[30:0]};
      fp_pkg::FpSgnjx: return {a[31] ^ b[31], a[30:0]};
      fp_pkg::FpMin, fp_pkg::FpMax: begin
        if (is_nan(a) && is_nan(b)) return fp_pkg::CanonicalNan;
        if (is_nan(a)) return b;
        if (is_nan(b)) return a;
        if (kind == fp_pkg::FpMin) return a_lo ? a : b;
        return a_lo ? b : a;
      end
      fp_pkg::FpLoad:  return ld;
      fp_pkg::FpMvWX:  return id;
      fp_pkg::FpStore: return b;
      fp_pkg::FpMvXW:  return a;
      default:         return 32'd0;
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    chk_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("FAILED %s expected %08h actual %08h at %0t", name, expected, actual, $time);
    end
  endtask

  // Model update on the same edge the DUT samples
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 32; i++) begin
        ref_regs[i] = 32'd0;
      end
      exp_q = '0;
    end else begin
      exp_q.store   = 1'b0;
      exp_q.mv_x    = 1'b0;
      exp_q.illegal = 1'b0;
      if (instr_valid_i) begin
        op  = classify(instr_i);
        res = ref_result(op, ref_regs[instr_i[19:15]], ref_regs[instr_i[24:20]],
                         load_data_i, int_data_i);
        case (op)
          fp_pkg::FpNone: exp_q.illegal = 1'b1;
          fp_pkg::FpStore: begin
            exp_q.store      = 1'b1;
            exp_q.store_data = res;
          end
          fp_pkg::FpMvXW: begin
            exp_q.mv_x     = 1'b1;
            exp_q.int_data = res;
          end
          default: ref_regs[instr_i[11:7]] = res;
        endcase
      end
    end
  end

  // Outputs are settled mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      compare("store_valid_o", {31'd0, exp_q.store}, {31'd0, store_valid_i});
      compare("store_data_o", exp_q.store_data, store_data_i);
      compare("int_valid_o", {31'd0, exp_q.mv_x}, {31'd0, int_valid_i});
      compare("int_data_o", exp_q.int_data, int_data_o_i);
      compare("illegal_o", {31'd0, exp_q.illegal}, {31'd0, illegal_i});
      compare("dbg_rdata_o", ref_regs[dbg_raddr_i], dbg_rdata_i);
    end
  end

endmodule

// File: rtl/fp_subsystem.sv
// Top level of the single-precision FP register subsystem.
// Takes one strobed instruction per cycle, writes results back a cycle
// later and emits registered store, FMV.X.W and illegal pulses.
// A debug read port exposes any register combinationally.

`timescale 1ns/1ps

module fp_subsystem (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        instr_valid_i,
  input  logic [31:0]                 instr_i,
  input  logic [fp_pkg::Flen-1:0]     load_data_i,
  input  logic [fp_pkg::Flen-1:0]     int_data_i,
  input  logic [fp_pkg::RegAddrW-1:0] dbg_raddr_i,
  output logic                        store_valid_o,
  output logic [fp_pkg::Flen-1:0]     store_data_o,
  output logic                        int_valid_o,
  output logic [fp_pkg::Flen-1:0]     int_data_o,
  output logic                        illegal_o,
  output logic [fp_pkg::Flen-1:0]     dbg_rdata_o
);

  // Outward one-cycle pulses
  typedef struct packed {
    logic store;
    logic mv_x;
    logic illegal;
  } pulse_t;

  fp_pkg::fp_ctrl_t        ctrl;
  logic [fp_pkg::Flen-1:0] rdata_a;
  logic [fp_pkg::Flen-1:0] rdata_b;
  logic [fp_pkg::Flen-1:0] alu_result;
  logic                    instr_ok;
  logic                    rf_we;
  pulse_t                  pulse_d;
  pulse_t                  pulse_q;
  logic [fp_pkg::Flen-1:0] store_data_q;
  logic [fp_pkg::Flen-1:0] int_data_q;

  fp_decoder u_decoder (
    .instr_i (instr_i),
    .ctrl_o  (ctrl)
  );

  fp_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (ctrl.rs1),
    .raddr_b_i (ctrl.rs2),
    .raddr_c_i (dbg_raddr_i),
    .waddr_i   (ctrl.rd),
    .wdata_i   (alu_result),
    .we_i      (rf_we),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .rdata_c_o (dbg_rdata_o)
  );

  fp_alu u_alu (
    .ctrl_i      (ctrl),
    .op_a_i      (rdata_a),
    .op_b_i      (rdata_b),
    .load_data_i (load_data_i),
    .int_data_i  (int_data_i),
    .result_o    (alu_result)
  );

  // Strobed and supported
  assign instr_ok = instr_valid_i && !ctrl.illegal;
  assign rf_we    = instr_ok && ctrl.we;

  assign pulse_d.store   = instr_ok && (ctrl.op == fp_pkg::FpStore);
  assign pulse_d.mv_x    = instr_ok && (ctrl.op == fp_pkg::FpMvXW);
  assign pulse_d.illegal = instr_valid_i && ctrl.illegal;

  // Pulses for one cycle, data held until the next event
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pulse_q      <= '0;
      store_data_q <= '0;
      int_data_q   <= '0;
    end else begin
      pulse_q <= pulse_d;
      if (pulse_d.store) begin
        store_data_q <= alu_result;
      end
      if (pulse_d.mv_x) begin
        int_data_q <= alu_result;
      end
    end
  end

  assign store_valid_o = pulse_q.store;
  assign store_data_o  = store_data_q;
  assign int_valid_o   = pulse_q.mv_x;
  assign int_data_o    = int_data_q;
  assign illegal_o     = pulse_q.illegal;

endmodule

// File: rtl/fp_alu.sv
// Combinational FP datapath for sign injection, min/max and moves.
// Produces the writeback value, and for FSW / FMV.X.W the outgoing
// data word, selected by the decoded operation.

`timescale 1ns/1ps

module fp_alu (
  input  fp_pkg::fp_ctrl_t        ctrl_i,
  input  logic [fp_pkg::Flen-1:0] op_a_i,
  input  logic [fp_pkg::Flen-1:0] op_b_i,
  input  logic [fp_pkg::Flen-1:0] load_data_i,
  input  logic [fp_pkg::Flen-1:0] int_data_i,
  output logic [fp_pkg::Flen-1:0] result_o
);

  // IEEE 754 binary32 layout
  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] man;
  } fp32_t;

  fp32_t                   a;
  fp32_t                   b;
  logic                    a_nan;
  logic                    b_nan;
  logic                    a_lt_b;
  logic                    sgnj_sign;
  logic [fp_pkg::Flen-1:0] sgnj_res;
  logic [fp_pkg::Flen-1:0] minmax_res;

  assign a = op_a_i;
  assign b = op_b_i;

  // Quiet and signaling NaN alike
  assign a_nan = (a.exp == 8'hff) && (a.man != '0);
  assign b_nan = (b.exp == 8'hff) && (b.man != '0);

  // New sign, magnitude always from a
  always_comb begin
    unique case (ctrl_i.op)
      fp_pkg::FpSgnjn: sgnj_sign = ~b.sign;
      fp_pkg::FpSgnjx: sgnj_sign = a.sign ^ b.sign;
      default:         sgnj_sign = b.sign;
    endcase
  end

  assign sgnj_res = {sgnj_sign, a.exp, a.man};

  // Sign-magnitude ordering
  // Differing signs also cover -0 < +0
  always_comb begin
    if (a.sign != b.sign) begin
      a_lt_b = a.sign;
    end else if (a.sign) begin
      // Both negative, larger magnitude is smaller
      a_lt_b = {a.exp, a.man} > {b.exp, b.man};
    end else begin
      a_lt_b = {a.exp, a.man} < {b.exp, b.man};
    end
  end

  always_comb begin
    if (a_nan && b_nan) begin
      minmax_res = fp_pkg::CanonicalNan;
    end else if (a_nan) begin
      minmax_res = op_b_i;
    end else if (b_nan) begin
      minmax_res = op_a_i;
    end else if (ctrl_i.op == fp_pkg::FpMax) begin
      minmax_res = a_lt_b ? op_b_i : op_a_i;
    end else begin
      minmax_res = a_lt_b ? op_a_i : op_b_i;
    end
  end

  // Final select
  always_comb begin
    unique case (ctrl_i.op)
      fp_pkg::FpSgnj, fp_pkg::FpSgnjn, fp_pkg::FpSgnjx: result_o = sgnj_res;
      fp_pkg::FpMin, fp_pkg::FpMax:                     result_o = minmax_res;
      fp_pkg::FpLoad:                                   result_o = load_data_i;
      fp_pkg::FpMvWX:                                   result_o = int_data_i;
      // Store data is rs2, FMV.X.W passes raw rs1 bits
      fp_pkg::FpStore:                                  result_o = op_b_i;
      fp_pkg::FpMvXW:                                   result_o = op_a_i;
      default:                                          result_o = '0;
    endcase
  end

endmodule

// File: rtl/fp_regfile.sv
// Flip-flop FP register file, 32 words of 32 bits.
// Three combinational read ports (two operands, one debug) and one
// write port; writes land on the next rising edge.

`timescale 1ns/1ps

module fp_regfile (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [fp_pkg::RegAddrW-1:0] raddr_a_i,
  input  logic [fp_pkg::RegAddrW-1:0] raddr_b_i,
  input  logic [fp_pkg::RegAddrW-1:0] raddr_c_i,
  input  logic [fp_pkg::RegAddrW-1:0] waddr_i,
  input  logic [fp_pkg::Flen-1:0]     wdata_i,
  input  logic                        we_i,
  output logic [fp_pkg::Flen-1:0]     rdata_a_o,
  output logic [fp_pkg::Flen-1:0]     rdata_b_o,
  output logic [fp_pkg::Flen-1:0]     rdata_c_o
);

  logic [fp_pkg::NumFpRegs-1:0][fp_pkg::Flen-1:0] regs_q;
  logic [fp_pkg::NumFpRegs-1:0]                   we_dec;

  // One-hot write select
  always_comb begin
    for (int unsigned i = 0; i < fp_pkg::NumFpRegs; i++) begin
      we_dec[i] = we_i && (waddr_i == fp_pkg::RegAddrW'(i));
    end
  end

  // All registers writable, f0 included
  for (genvar i = 0; i < fp_pkg::NumFpRegs; i++) begin : g_regs
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        regs_q[i] <= '0;
      end else if (we_dec[i]) begin
        regs_q[i] <= wdata_i;
      end
    end
  end

  // Read muxes, no bypass
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];
  assign rdata_c_o = regs_q[raddr_c_i];

endmodule

// File: rtl/fp_decoder.sv
// Combinational decoder for the supported F-extension subset.
// Maps a raw 32-bit instruction to an fp_ctrl_t and flags anything else
// as illegal. The illegal flag is not qualified by a valid strobe.

`timescale 1ns/1ps

module fp_decoder (
  input  logic [31:0]      instr_i,
  output fp_pkg::fp_ctrl_t ctrl_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] funct5;
  logic [1:0] fmt;
  logic [4:0] rs2_field;

  // Standard RISC-V field positions
  assign opcode    = instr_i[6:0];
  assign funct3    = instr_i[14:12];
  assign fmt       = instr_i[26:25];
  assign funct5    = instr_i[31:27];
  assign rs2_field = instr_i[24:20];

  always_comb begin
    // Register fields always taken from the word
    ctrl_o.rd      = instr_i[11:7];
    ctrl_o.rs1     = instr_i[19:15];
    ctrl_o.rs2     = rs2_field;
    // Default is an unsupported encoding
    ctrl_o.op      = fp_pkg::FpNone;
    ctrl_o.we      = 1'b0;
    ctrl_o.illegal = 1'b1;

    unique case (opcode)
      fp_pkg::OpcodeLoadFp: begin
        // FLW, data comes in on the load port
        if (funct3 == fp_pkg::Funct3Word) begin
          ctrl_o.op      = fp_pkg::FpLoad;
          ctrl_o.we      = 1'b1;
          ctrl_o.illegal = 1'b0;
        end
      end
      fp_pkg::OpcodeStoreFp: begin
        // FSW, rs2 is the data source
        if (funct3 == fp_pkg::Funct3Word) begin
          ctrl_o.op      = fp_pkg::FpStore;
          ctrl_o.illegal = 1'b0;
        end
      end
      fp_pkg::OpcodeOpFp: begin
        // Only the S format is handled
        if (fmt == fp_pkg::FmtSingle) begin
          unique case (funct5)
            fp_pkg::Funct5Sgnj: begin
              ctrl_o.we      = (funct3 <= 3'b010);
              ctrl_o.illegal = (funct3 > 3'b010);
              if (funct3 == 3'b000) ctrl_o.op = fp_pkg::FpSgnj;
              else if (funct3 == 3'b001) ctrl_o.op = fp_pkg::FpSgnjn;
              else if (funct3 == 3'b010) ctrl_o.op = fp_pkg::FpSgnjx;
            end
            fp_pkg::Funct5MinMax: begin
              ctrl_o.we      = (funct3 <= 3'b001);
              ctrl_o.illegal = (funct3 > 3'b001);
              if (funct3 == 3'b000) ctrl_o.op = fp_pkg::FpMin;
              else if (funct3 == 3'b001) ctrl_o.op = fp_pkg::FpMax;
            end
            fp_pkg::Funct5MvXW: begin
              // funct3 001 would be FCLASS, not supported
              if ((rs2_field == '0) && (funct3 == 3'b000)) begin
                ctrl_o.op      = fp_pkg::FpMvXW;
                ctrl_o.illegal = 1'b0;
              end
            end
            fp_pkg::Funct5MvWX: begin
              if ((rs2_field == '0) && (funct3 == 3'b000)) begin
                ctrl_o.op      = fp_pkg::FpMvWX;
                ctrl_o.we      = 1'b1;
                ctrl_o.illegal = 1'b0;
              end
            end
            default: ;
          endcase
        end
      end
      default: ;
    endcase
  end

endmodule

// File: rtl/fp_pkg.sv
// Shared definitions for the single-precision FP register subsystem.
// Holds data and address widths, RISC-V F-extension encoding constants,
// the operation enum and the decoded control struct.
// Every RTL file refers to these by scoped name.

package fp_pkg;

  // Data and register file geometry
  localparam int unsigned Flen      = 32;
  localparam int unsigned NumFpRegs = 32;
  localparam int unsigned RegAddrW  = 5;

  // RISC-V canonical quiet NaN
  localparam logic [Flen-1:0] CanonicalNan = 32'h7fc0_0000;

  // Major opcodes
  localparam logic [6:0] OpcodeLoadFp  = 7'b000_0111;
  localparam logic [6:0] OpcodeStoreFp = 7'b010_0111;
  localparam logic [6:0] OpcodeOpFp    = 7'b101_0011;

  // Width field of FLW / FSW
  localparam logic [2:0] Funct3Word = 3'b010;

  // OP-FP funct5, upper bits of funct7
  localparam logic [4:0] Funct5Sgnj   = 5'b00100;
  localparam logic [4:0] Funct5MinMax = 5'b00101;
  localparam logic [4:0] Funct5MvXW   = 5'b11100;
  localparam logic [4:0] Funct5MvWX   = 5'b11110;

  // fmt field, low bits of funct7; S only
  localparam logic [1:0] FmtSingle = 2'b00;

  typedef enum logic [3:0] {
    FpNone,
    FpSgnj,
    FpSgnjn,
    FpSgnjx,
    FpMin,
    FpMax,
    FpLoad,
    FpStore,
    FpMvWX,
    FpMvXW
  } fp_op_e;

  // Decoded instruction, one per cycle
  typedef struct packed {
    fp_op_e              op;
    logic [RegAddrW-1:0] rd;
    logic [RegAddrW-1:0] rs1;
    logic [RegAddrW-1:0] rs2;
    logic                we;
    logic                illegal;
  } fp_ctrl_t;

endpackage
